/* logic/print_pkg.sv */
`default_nettype none

package print_pkg;

    // print sequencer states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        SEND,
        WAIT_TX,
        ACK
    } print_state_e;

    // opcode decoded from the wishbone word address
    typedef enum logic [1:0] {
        OP_BYTE = 2'd0,   // raw character
        OP_WORD = 2'd1,   // XXXX_XXXX hex dump
        OP_NONE = 2'd2    // unmapped, ack only
    } print_op_e;

    localparam int WORD_CHARS     = 9;    // 8 hex digits plus underscore
    localparam int CHAR_IDX_W     = 4;
    localparam int UNDERSCORE_POS = 4;    // slot between the two half words
    localparam int CNT_W          = 16;   // printed character counter

    localparam logic [7:0] ASCII_ZERO       = 8'h30;
    localparam logic [7:0] ASCII_A          = 8'h41;
    localparam logic [7:0] ASCII_UNDERSCORE = 8'h5F;

endpackage

`default_nettype wire

/* logic/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // short bit time so simulation stays fast
    localparam int CLKS_PER_BIT = 16;
    localparam int TICK_CNT_W   = $clog2(CLKS_PER_BIT);

    // 8N1 frame: start, 8 data bits lsb first, stop
    localparam int FRAME_BITS = 10;
    localparam int BIT_CNT_W  = 4;

endpackage

`default_nettype wire

/* logic/print_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module print_ctrl_fsm
    import print_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [1:0]            wb_adr,
    input  logic [31:0]           wb_dat_i,
    output logic [31:0]           wb_dat_o,
    output logic                  wb_ack,
    output logic [31:0]           value,      // latched write data
    output print_op_e             op,         // latched opcode
    output logic [CHAR_IDX_W-1:0] char_idx,   // position within the print
    input  logic [7:0]            char,       // from the character selector
    output logic                  char_vld,
    input  logic                  char_rdy,
    output logic [7:0]            char_data
);

    print_state_e         state;
    print_op_e            op_dec;
    logic [CNT_W-1:0]     char_cnt;
    logic                 last_char;

    // address decode, only meaningful while a cycle is pending
    always_comb begin
        case (wb_adr)
            2'd0:    op_dec = OP_BYTE;
            2'd1:    op_dec = OP_WORD;
            default: op_dec = OP_NONE;
        endcase
    end

    // a byte print is one character, a word print is WORD_CHARS
    assign last_char = (op == OP_BYTE) ||
                       (char_idx == CHAR_IDX_W'(WORD_CHARS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= IDLE;
            op       <= OP_NONE;
            char_idx <= '0;
            char_vld <= 1'b0;
            char_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (wb_cyc && wb_stb) begin
                        if (wb_we && op_dec != OP_NONE)
                            state <= LOAD;
                        else
                            state <= ACK;   // reads and unmapped writes
                    end
                end
                LOAD: begin
                    op       <= op_dec;
                    char_idx <= '0;
                    state    <= SEND;
                end
                SEND: begin
                    char_vld <= 1'b1;
                    state    <= WAIT_TX;
                end
                WAIT_TX: begin
                    if (char_rdy) begin             // transfer on this edge
                        char_vld <= 1'b0;
                        char_idx <= char_idx + 1'b1;
                        char_cnt <= char_cnt + 1'b1;
                        state    <= last_char ? ACK : SEND;
                    end
                end
                ACK: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state == LOAD)
            value <= wb_dat_i;
        if (state == SEND)
            char_data <= char;   // held until the transmitter takes it
    end

    assign wb_ack   = (state == ACK);
    assign wb_dat_o = {{(32 - CNT_W){1'b0}}, char_cnt};

endmodule

`default_nettype wire

/* logic/print_char_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module print_char_sel
    import print_pkg::*;
(
    input  logic [31:0]           value,
    input  print_op_e             op,
    input  logic [CHAR_IDX_W-1:0] char_idx,
    output logic [7:0]            char
);

    logic [2:0] nib_sel;    // nibble number, 7 is the top one
    logic [3:0] nibble;
    logic [7:0] hex_char;

    always_comb begin
        // digits before the underscore map 0..3 -> 7..4, after it 5..8 -> 3..0
        if (char_idx < UNDERSCORE_POS)
            nib_sel = 3'(4'd7 - char_idx);
        else
            nib_sel = 3'(4'd8 - char_idx);

        nibble = value[{nib_sel, 2'b00} +: 4];

        if (nibble < 4'd10)
            hex_char = ASCII_ZERO + {4'h0, nibble};
        else
            hex_char = ASCII_A + {4'h0, nibble} - 8'd10;

        case (op)
            OP_BYTE: char = value[7:0];   // printed as is
            OP_WORD: char = (char_idx == UNDERSCORE_POS) ? ASCII_UNDERSCORE : hex_char;
            default: char = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* logic/baud_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module baud_timer
    import uart_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic restart,   // frame start, realigns the bit grid
    output logic bit_tick
);

    localparam logic [TICK_CNT_W-1:0] RELOAD = TICK_CNT_W'(CLKS_PER_BIT - 1);

    logic [TICK_CNT_W-1:0] tick_cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            tick_cnt <= RELOAD;
        else if (restart || tick_cnt == '0)
            tick_cnt <= RELOAD;              // restart wins over a pending tick
        else
            tick_cnt <= tick_cnt - 1'b1;
    end

    // one cycle pulse, CLKS_PER_BIT cycles after each reload
    assign bit_tick = (tick_cnt == '0);

endmodule

`default_nettype wire

/* logic/uart_tx_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_shift
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       char_vld,
    input  logic [7:0] char_data,
    output logic       char_rdy,
    output logic       bit_restart,
    input  logic       bit_tick,
    output logic       tx
);

    logic                  busy;
    logic [FRAME_BITS-1:0] frame;     // bit 0 is on the line
    logic [BIT_CNT_W-1:0]  bit_cnt;   // bits already finished
    logic                  accept;

    assign char_rdy    = !busy;
    assign accept      = char_vld && char_rdy;
    assign bit_restart = accept;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy    <= 1'b0;
            frame   <= '1;   // idle line is high
            bit_cnt <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            frame   <= {1'b1, char_data, 1'b0};   // stop, data, start
            bit_cnt <= '0;
        end else if (busy && bit_tick) begin
            frame   <= {1'b1, frame[FRAME_BITS-1:1]};   // shift in idle ones
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1))
                busy <= 1'b0;   // stop bit done
        end
    end

    assign tx = frame[0];

endmodule

`default_nettype wire

/* logic/print_top.sv */
`timescale 1ns/1ps
`default_nettype none

module print_top
    import print_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:2]  wb_adr,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack,
    output logic        tx
);

    logic [31:0]           value;
    print_op_e             op;
    logic [CHAR_IDX_W-1:0] char_idx;
    logic [7:0]            char;
    logic                  char_vld;
    logic                  char_rdy;
    logic [7:0]            char_data;
    logic                  bit_restart;
    logic                  bit_tick;

    print_ctrl_fsm ctrl_i (
        .clk       (clk),
        .rstn      (rstn),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .value     (value),
        .op        (op),
        .char_idx  (char_idx),
        .char      (char),
        .char_vld  (char_vld),
        .char_rdy  (char_rdy),
        .char_data (char_data)
    );

    print_char_sel sel_i (
        .value    (value),
        .op       (op),
        .char_idx (char_idx),
        .char     (char)
    );

    baud_timer timer_i (
        .clk      (clk),
        .rstn     (rstn),
        .restart  (bit_restart),
        .bit_tick (bit_tick)
    );

    uart_tx_shift tx_i (
        .clk         (clk),
        .rstn        (rstn),
        .char_vld    (char_vld),
        .char_data   (char_data),
        .char_rdy    (char_rdy),
        .bit_restart (bit_restart),
        .bit_tick    (bit_tick),
        .tx          (tx)
    );

endmodule

`default_nettype wire

/* tb/print_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module print_sva (
    input logic       clk,
    input logic       rstn,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       char_vld,
    input logic       char_rdy,
    input logic [7:0] char_data,
    input logic       tx
);

    int fail_cnt = 0;   // read by the testbench for the closing report

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rstn) wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack stayed high for more than one cycle");
            fail_cnt++;
        end

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rstn)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("wb_ack raised outside a bus cycle");
            fail_cnt++;
        end

    // a waiting character keeps its valid and its data
    char_hold: assert property (@(posedge clk) disable iff (!rstn)
        (char_vld && !char_rdy) |=> (char_vld && $stable(char_data)))
        else begin
            $error("char_data or char_vld changed before the transmitter took it");
            fail_cnt++;
        end

    tx_idle_high: assert property (@(posedge clk) disable iff (!rstn) char_rdy |-> tx)
        else begin
            $error("tx low while the transmitter is idle");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* tb/print_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module print_checker
    import print_pkg::*, uart_pkg::*;
(
    input logic        clk,
    input logic        rstn,
    input logic        tx,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_we,
    input logic [1:0]  wb_adr,
    input logic [31:0] wb_dat_i,
    input logic [31:0] wb_dat_o,
    input logic        wb_ack
);

    string      test_name = "reset";
    int         value_errs = 0;
    int         other_errs = 0;
    int         pending = 0;       // expected characters not yet received
    int         exp_total = 0;     // characters expected since reset
    int         starts_seen = 0;   // start bits seen on tx
    int         start_mark;
    int         cyc_edges;
    int         cyc_len;
    int         reset_edges = 0;
    logic       in_cycle = 1'b0;
    logic       cyc_we;
    logic [7:0] exp_q[$];
    logic [7:0] rx_byte;
    event       rx_done;

    function automatic int expected_len(input logic [1:0] adr);
        if (adr == 2'd0)
            return 1;
        if (adr == 2'd1)
            return WORD_CHARS;
        return 0;   // nothing printed for an unmapped address
    endfunction

    // character idx of the print text for a write of val to adr
    function automatic logic [7:0] expected_char(input logic [1:0] adr, input logic [31:0] val,
                                                 input int idx);
        string text;
        if (adr == 2'd0)
            return val[7:0];
        text = $sformatf("%04h_%04h", val[31:16], val[15:0]);   // XXXX_XXXX
        text = text.toupper();
        return text[idx];
    endfunction

    task check_drained();
        if (exp_q.size() != 0) begin
            $display("%0d expected characters never appeared on tx", exp_q.size());
            other_errs++;
        end
    endtask

    // wishbone monitor queues the expected text at the start of each cycle
    always @(posedge clk) begin
        if (!rstn) begin
            in_cycle = 1'b0;
            if (reset_edges > 0 && (tx !== 1'b1 || wb_ack !== 1'b0)) begin
                $display("tx not idle or ack raised during reset");
                other_errs++;
            end
            reset_edges++;
        end else if (wb_cyc && wb_stb) begin
            if (!in_cycle) begin
                in_cycle   = 1'b1;
                cyc_edges  = 0;
                cyc_we     = wb_we;
                cyc_len    = wb_we ? expected_len(wb_adr) : 0;
                start_mark = starts_seen;
                for (int i = 0; i < cyc_len; i++)
                    exp_q.push_back(expected_char(wb_adr, wb_dat_i, i));
                exp_total += cyc_len;
                pending    = exp_q.size();
            end
            cyc_edges++;
            if (wb_ack) begin
                in_cycle = 1'b0;
                if (cyc_len == 0 && cyc_edges != 2) begin
                    $display("ack came on edge %0d of a short cycle in %s", cyc_edges, test_name);
                    other_errs++;
                end
                if (!cyc_we && wb_dat_o !== 32'(exp_total)) begin
                    $display("error %s: read count expected %0d actual %0d",
                             test_name, exp_total, wb_dat_o);
                    value_errs++;
                end
                if (cyc_len != 0 && starts_seen - start_mark != cyc_len) begin
                    $display("ack arrived in %s with %0d characters not yet started on tx",
                             test_name, cyc_len - (starts_seen - start_mark));
                    other_errs++;
                end
            end
        end
    end

    // uart receiver samples every bit at its middle
    initial begin : uart_rx
        logic [7:0] data;
        forever begin
            @(negedge tx);
            if (rstn) begin
                starts_seen++;
                repeat (CLKS_PER_BIT / 2) @(posedge clk);
                if (tx !== 1'b0) begin
                    $display("start bit on tx ended before mid-bit");
                    other_errs++;
                end
                for (int b = 0; b < FRAME_BITS - 2; b++) begin
                    repeat (CLKS_PER_BIT) @(posedge clk);
                    data[b] = tx;   // lsb first
                end
                repeat (CLKS_PER_BIT) @(posedge clk);
                if (tx !== 1'b1) begin
                    $display("stop bit missing on tx");
                    other_errs++;
                end
                rx_byte = data;
                -> rx_done;
            end
        end
    end

    initial begin : compare
        logic [7:0] exp_char;
        forever begin
            @(rx_done);
            if (exp_q.size() == 0) begin
                $display("unexpected character 0x%02h on tx in %s", rx_byte, test_name);
                other_errs++;
            end else begin
                exp_char = exp_q.pop_front();
                pending  = exp_q.size();
                if (rx_byte !== exp_char) begin
                    $display("error %s: expected 0x%02h actual 0x%02h",
                             test_name, exp_char, rx_byte);
                    value_errs++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_print.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_print
    import print_pkg::*, uart_pkg::*;
();

    // about 20 word prints of WORD_CHARS frames each, plus margin
    localparam int TIMEOUT_CYCLES = 20 * WORD_CHARS * FRAME_BITS * CLKS_PER_BIT + 11200;

    logic        clk;
    logic        rstn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:2]  wb_adr;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;
    logic        tx;
    int          seed = 32'hb7d2_19a0;
    int          timeout_errs = 0;

    print_top dut_i (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .tx       (tx)
    );

    print_checker chk_i (
        .clk      (clk),
        .rstn     (rstn),
        .tx       (tx),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    bind print_top print_sva sva_i (
        .clk       (clk),
        .rstn      (rstn),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_ack    (wb_ack),
        .char_vld  (char_vld),
        .char_rdy  (char_rdy),
        .char_data (char_data),
        .tx        (tx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // wait for ack, then release the bus 1 ns after that edge
    task end_cycle();
        @(posedge clk);
        while (!wb_ack)
            @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task write_reg(input logic [1:0] adr, input logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = data;
        end_cycle();
    endtask

    task read_count();
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = 2'd0;
        end_cycle();
    endtask

    task report_and_finish();
        int total;
        total = chk_i.value_errs + chk_i.other_errs + dut_i.sva_i.fail_cnt + timeout_errs;
        $display("errors: %0d value, %0d protocol, %0d assertion, %0d timeout",
                 chk_i.value_errs, chk_i.other_errs, dut_i.sva_i.fail_cnt, timeout_errs);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        timeout_errs = 1;
        report_and_finish();
    end

    initial begin : stimulus
        int drain;
        rstn     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_dat_i = '0;
        repeat (4) @(posedge clk);
        #1 rstn = 1'b1;
        idle_cycles(20);   // line must stay quiet without a write
        chk_i.test_name = "reset_count";
        read_count();
        chk_i.test_name = "byte_print";
        write_reg(2'd0, 32'h0000_0041);
        for (int i = 0; i < 6; i++)
            write_reg(2'd0, $random(seed));
        read_count();
        idle_cycles(3);
        chk_i.test_name = "word_print";
        write_reg(2'd1, 32'hDEAD_BEEF);
        write_reg(2'd1, 32'h0000_0000);
        write_reg(2'd1, 32'hFFFF_FFFF);
        for (int i = 0; i < 4; i++)
            write_reg(2'd1, $random(seed));
        read_count();
        chk_i.test_name = "undef_addr";
        write_reg(2'd2, $random(seed));
        write_reg(2'd3, $random(seed));
        read_count();
        chk_i.test_name = "back_to_back";
        write_reg(2'd1, $random(seed));
        write_reg(2'd0, $random(seed));
        write_reg(2'd1, $random(seed));
        read_count();
        chk_i.test_name = "drain";
        drain = 0;
        while (chk_i.pending != 0 && drain < 2 * FRAME_BITS * CLKS_PER_BIT) begin
            @(posedge clk);
            drain++;
        end
        chk_i.check_drained();
        report_and_finish();
    end

endmodule

`default_nettype wire

/* flist.f */
logic/print_pkg.sv
logic/uart_pkg.sv
logic/print_ctrl_fsm.sv
logic/print_char_sel.sv
logic/baud_timer.sv
logic/uart_tx_shift.sv
logic/print_top.sv
tb/print_sva.sv
tb/print_checker.sv
tb/tb_print.sv
